//--- noc_router.f
hdl/noc_pkg.sv
hdl/input_port.sv
hdl/switch_alloc.sv
hdl/switch_traversal.sv
hdl/noc_router.sv
tb/tb_noc_router.sv

//--- Bender.yml
package:
  name: noc_router

sources:
  - hdl/noc_pkg.sv
  - hdl/input_port.sv
  - hdl/switch_alloc.sv
  - hdl/switch_traversal.sv
  - hdl/noc_router.sv
  - target: test
    files:
      - tb/tb_noc_router.sv

//--- tb/tb_noc_router.sv
`timescale 1ns/1ps
`default_nettype none

module tb_noc_router import noc_pkg::*; ();

	// the five tests need a few hundred cycles at most
	localparam int CYCLE_LIMIT = 3000;
	localparam int SETTLE = 8;
	localparam int PKT_LEN = 4;

	typedef struct packed {
		port_idx_t port;
		logic [31:0] cyc;
		flit_t flit;
	} rx_rec_t;

	logic clk;
	logic rst;
	link_t link_in [PORT_NUM];
	port_vec_t credit_in;
	link_t link_out [PORT_NUM];
	port_vec_t credit_out;

	int cyc;
	int errors;
	int err_at_start;
	int tests_run;
	int tests_failed;
	rx_rec_t rx_log [$];
	int credit_seen [PORT_NUM];
	int credit_last [PORT_NUM];
	int tx_credits [PORT_NUM];
	int credit_owed [PORT_NUM];
	int sent_cyc [PORT_NUM];
	port_vec_t credit_due;
	port_vec_t credit_hold;
	flit_t stim [PORT_NUM][8];
	int stim_len [PORT_NUM];

	noc_router DUT (
		.clk(clk),
		.rst(rst),
		.link_in(link_in),
		.credit_in(credit_in),
		.link_out(link_out),
		.credit_out(credit_out)
	);

	always #50 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// outputs sampled mid cycle
	always @(negedge clk) begin
		rx_rec_t rec;
		if (!rst) begin
			for (int p = 0; p < PORT_NUM; p++) begin
				if (link_out[p].wr_en) begin
					rec.port = port_idx_t'(p);
					rec.cyc = cyc;
					rec.flit = link_out[p].flit;
					rx_log.push_back(rec);
				end
				if (credit_out[p]) begin
					credit_seen[p]++;
					credit_last[p] = cyc;
					tx_credits[p]++;
				end
				credit_due[p] = link_out[p].wr_en;
			end
		end
	end

	// downstream model returns one credit per received flit unless held
	always @(posedge clk) begin
		#1;
		for (int p = 0; p < PORT_NUM; p++) begin
			credit_in[p] = (credit_due[p] && !credit_hold[p]) || (credit_owed[p] > 0);
			if (credit_owed[p] > 0)
				credit_owed[p]--;
		end
	end

	initial begin
		while (cyc < CYCLE_LIMIT)
			@(posedge clk);
		$display("timeout: run stopped after %0d cycles", CYCLE_LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

	// dimension order model resolves x before y
	function automatic int xy_port(input int dx, input int dy);
		if (dx != ROUTER_X)
			return (dx > ROUTER_X) ? int'(PORT_EAST) : int'(PORT_WEST);
		if (dy != ROUTER_Y)
			return (dy > ROUTER_Y) ? int'(PORT_NORTH) : int'(PORT_SOUTH);
		return int'(PORT_LOCAL);
	endfunction

	function automatic flit_t make_flit(input flit_kind_e kind, input int dx, input int dy);
		flit_t f;
		f.kind = kind;
		f.dest_x = ADDR_X_W'(dx);
		f.dest_y = ADDR_Y_W'(dy);
		f.data = DATA_W'($urandom());
		return f;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (exp === act)
		else begin
			$display("Error %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond)
		else begin
			$display("%s", msg);
			errors++;
		end
	endtask

	task automatic check_rx(input string name, input int idx, input int port, input flit_t f);
		if (idx < rx_log.size()) begin
			check_equal({name, " port"}, port, rx_log[idx].port);
			check_equal({name, " flit"}, f, rx_log[idx].flit);
		end else begin
			check_true(1'b0, $sformatf("%s: flit %0d never left the router", name, idx));
		end
	endtask

	// one flit per cycle while the input port has credits
	task automatic send_stim(input int port);
		for (int i = 0; i < stim_len[port]; i++) begin
			@(posedge clk);
			#1;
			while (tx_credits[port] == 0) begin
				link_in[port].wr_en = 1'b0;
				@(posedge clk);
				#1;
			end
			link_in[port].flit = stim[port][i];
			link_in[port].wr_en = 1'b1;
			tx_credits[port]--;
			sent_cyc[port] = cyc + 1;
		end
		@(posedge clk);
		#1;
		link_in[port].wr_en = 1'b0;
	endtask

	// block until n flits have left the router
	task automatic wait_rx(input int n);
		while (rx_log.size() < n)
			@(posedge clk);
	endtask

	task automatic return_credits(input int port, input int n);
		@(negedge clk);
		credit_owed[port] += n;
		while (credit_owed[port] != 0)
			@(negedge clk);
	endtask

	task automatic start_test();
		rx_log.delete();
		for (int p = 0; p < PORT_NUM; p++)
			credit_seen[p] = 0;
		err_at_start = errors;
	endtask

	task automatic end_test(input string name);
		// let the last credits come home
		repeat (3) @(posedge clk);
		tests_run++;
		if (errors == err_at_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_at_start);
		end
	endtask

	task automatic test_reset();
		start_test();
		repeat (2) begin
			@(negedge clk);
			for (int p = 0; p < PORT_NUM; p++)
				check_equal($sformatf("reset wr_en %0d", p), 0, link_out[p].wr_en);
			check_equal("reset credit_out", 0, credit_out);
		end
		credit_hold[PORT_NORTH] = 1'b1;
		stim_len[PORT_LOCAL] = BUF_DEPTH + 1;
		for (int i = 0; i < BUF_DEPTH + 1; i++)
			stim[PORT_LOCAL][i] = make_flit(FLIT_SINGLE, 2, 2);
		send_stim(PORT_LOCAL);
		wait_rx(BUF_DEPTH);
		repeat (SETTLE) @(posedge clk);
		check_equal("reset credit limit", BUF_DEPTH, rx_log.size());
		return_credits(PORT_NORTH, 1);
		wait_rx(BUF_DEPTH + 1);
		for (int i = 0; i < BUF_DEPTH + 1; i++)
			check_rx("reset", i, PORT_NORTH, stim[PORT_LOCAL][i]);
		return_credits(PORT_NORTH, BUF_DEPTH);
		credit_hold[PORT_NORTH] = 1'b0;
		end_test("reset");
	endtask

	task automatic test_latency();
		flit_t f;
		start_test();
		f = make_flit(FLIT_SINGLE, ROUTER_X, ROUTER_Y);
		stim[PORT_EAST][0] = f;
		stim_len[PORT_EAST] = 1;
		send_stim(PORT_EAST);
		wait_rx(1);
		repeat (2) @(posedge clk);
		check_equal("latency flit count", 1, rx_log.size());
		check_rx("latency", 0, PORT_LOCAL, f);
		check_equal("latency cycles", sent_cyc[PORT_EAST] + 2, rx_log[0].cyc);
		// credit pulse is registered at the same edge as the output flit
		check_equal("latency credit count", 1, credit_seen[PORT_EAST]);
		check_equal("latency credit cycle", sent_cyc[PORT_EAST] + 2, credit_last[PORT_EAST]);
		end_test("latency");
	endtask

	task automatic test_xy();
		int dx [5];
		int dy [5];
		start_test();
		dx = '{3, 0, 2, 2, 2};
		dy = '{0, 2, 0, 2, 1};
		stim_len[PORT_LOCAL] = 5;
		for (int i = 0; i < 5; i++)
			stim[PORT_LOCAL][i] = make_flit(FLIT_SINGLE, dx[i], dy[i]);
		send_stim(PORT_LOCAL);
		wait_rx(5);
		repeat (SETTLE) @(posedge clk);
		check_equal("xy flit count", 5, rx_log.size());
		for (int i = 0; i < 5; i++)
			check_rx("xy", i, xy_port(dx[i], dy[i]), stim[PORT_LOCAL][i]);
		end_test("xy routing");
	endtask

	task automatic test_wormhole();
		flit_kind_e kind;
		int first;
		int second;
		start_test();
		for (int i = 0; i < PKT_LEN; i++) begin
			if (i == 0)
				kind = FLIT_HEAD;
			else if (i == PKT_LEN - 1)
				kind = FLIT_TAIL;
			else
				kind = FLIT_BODY;
			stim[PORT_WEST][i] = make_flit(kind, 3, 1);
			stim[PORT_SOUTH][i] = make_flit(kind, 3, 2);
		end
		stim_len[PORT_WEST] = PKT_LEN;
		stim_len[PORT_SOUTH] = PKT_LEN;
		fork
			send_stim(PORT_WEST);
			send_stim(PORT_SOUTH);
		join
		wait_rx(2 * PKT_LEN);
		repeat (SETTLE) @(posedge clk);
		check_equal("wormhole flit count", 2 * PKT_LEN, rx_log.size());
		// either packet may win, but the other must follow it whole
		first = PORT_WEST;
		if (rx_log.size() > 0 && rx_log[0].flit == stim[PORT_SOUTH][0])
			first = PORT_SOUTH;
		second = (first == PORT_WEST) ? int'(PORT_SOUTH) : int'(PORT_WEST);
		for (int i = 0; i < PKT_LEN; i++) begin
			check_rx("wormhole first", i, PORT_EAST, stim[first][i]);
			check_rx("wormhole second", i + PKT_LEN, PORT_EAST, stim[second][i]);
		end
		end_test("wormhole");
	endtask

	task automatic test_backpressure();
		start_test();
		credit_hold[PORT_EAST] = 1'b1;
		stim_len[PORT_LOCAL] = 6;
		for (int i = 0; i < 6; i++)
			stim[PORT_LOCAL][i] = make_flit(FLIT_SINGLE, 3, 1);
		send_stim(PORT_LOCAL);
		wait_rx(BUF_DEPTH);
		repeat (SETTLE) @(posedge clk);
		check_equal("backpressure held count", BUF_DEPTH, rx_log.size());
		return_credits(PORT_EAST, 2);
		wait_rx(6);
		repeat (SETTLE) @(posedge clk);
		check_equal("backpressure flit count", 6, rx_log.size());
		for (int i = 0; i < 6; i++)
			check_rx("backpressure", i, PORT_EAST, stim[PORT_LOCAL][i]);
		return_credits(PORT_EAST, BUF_DEPTH);
		credit_hold[PORT_EAST] = 1'b0;
		end_test("backpressure");
	endtask

	initial begin
		void'($urandom(32'hda92));
		clk = 1'b0;
		rst = 1'b1;
		credit_in = '0;
		credit_due = '0;
		credit_hold = '0;
		cyc = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int p = 0; p < PORT_NUM; p++) begin
			link_in[p] = '0;
			tx_credits[p] = BUF_DEPTH;
			credit_owed[p] = 0;
			stim_len[p] = 0;
		end
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		test_reset();
		test_latency();
		test_xy();
		test_wormhole();
		test_backpressure();
		$display("tests run %0d, tests failing %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/noc_router.sv
`timescale 1ns/1ps
`default_nettype none

module noc_router import noc_pkg::*; (
	input logic clk,
	input logic rst,
	input link_t link_in [PORT_NUM],
	input port_vec_t credit_in,
	output link_t link_out [PORT_NUM],
	output port_vec_t credit_out
);

	flit_t head_flit [PORT_NUM];
	port_vec_t req_valid;
	port_vec_t req_tail;
	port_idx_t req_port [PORT_NUM];
	port_vec_t pop;
	port_idx_t out_sel [PORT_NUM];
	port_vec_t out_send;
	port_vec_t credit_avail;

	// buffering and route computation per input
	genvar i;
	generate
		for (i = 0; i < PORT_NUM; i++) begin : gen_in_port
			input_port u_input_port (
				.clk(clk),
				.rst(rst),
				.port_id(port_idx_t'(i)),
				.link_in(link_in[i]),
				.pop(pop[i]),
				.head_flit(head_flit[i]),
				.req_valid(req_valid[i]),
				.req_tail(req_tail[i]),
				.req_port(req_port[i]),
				.credit_out(credit_out[i])
			);
		end
	endgenerate

	switch_alloc u_switch_alloc (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_tail(req_tail),
		.req_port(req_port),
		.credit_avail(credit_avail),
		.pop(pop),
		.out_sel(out_sel),
		.out_send(out_send)
	);

	switch_traversal u_switch_traversal (
		.clk(clk),
		.rst(rst),
		.head_flit(head_flit),
		.out_sel(out_sel),
		.out_send(out_send),
		.credit_in(credit_in),
		.credit_avail(credit_avail),
		.link_out(link_out)
	);

endmodule

`default_nettype wire

//--- hdl/switch_traversal.sv
`timescale 1ns/1ps
`default_nettype none

module switch_traversal import noc_pkg::*; (
	input logic clk,
	input logic rst,
	input flit_t head_flit [PORT_NUM],
	input port_idx_t out_sel [PORT_NUM],
	input port_vec_t out_send,
	input port_vec_t credit_in,
	output port_vec_t credit_avail,
	output link_t link_out [PORT_NUM]
);

	port_vec_t out_wr_q;
	flit_t out_flit_q [PORT_NUM];
	logic [CREDIT_W-1:0] credit_cnt [PORT_NUM];

	// output link strobes
	always_ff @(posedge clk) begin
		if (rst)
			out_wr_q <= '0;
		else
			out_wr_q <= out_send;
	end

	// crossbar mux into the output register
	always_ff @(posedge clk) begin
		for (int o = 0; o < PORT_NUM; o++) begin
			if (out_send[o])
				out_flit_q[o] <= head_flit[out_sel[o]];
		end
	end

	always_comb begin
		for (int o = 0; o < PORT_NUM; o++) begin
			link_out[o].wr_en = out_wr_q[o];
			link_out[o].flit = out_flit_q[o];
		end
	end

	// downstream buffer space starts full
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int o = 0; o < PORT_NUM; o++)
				credit_cnt[o] <= CREDIT_W'(BUF_DEPTH);
		end else begin
			for (int o = 0; o < PORT_NUM; o++) begin
				credit_cnt[o] <= credit_cnt[o]
					- CREDIT_W'(out_send[o])
					+ CREDIT_W'(credit_in[o]);
			end
		end
	end

	always_comb begin
		for (int o = 0; o < PORT_NUM; o++)
			credit_avail[o] = credit_cnt[o] != '0;
	end

	// downstream returns no more slots than it owns
	genvar g;
	generate
		for (g = 0; g < PORT_NUM; g++) begin : gen_credit_chk
			a_credit_max: assert property (@(posedge clk) disable iff (rst)
				credit_cnt[g] <= CREDIT_W'(BUF_DEPTH));
		end
	endgenerate

endmodule

`default_nettype wire

//--- hdl/switch_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module switch_alloc import noc_pkg::*; (
	input logic clk,
	input logic rst,
	input port_vec_t req_valid,
	input port_vec_t req_tail,
	input port_idx_t req_port [PORT_NUM],
	input port_vec_t credit_avail,
	output port_vec_t pop,
	output port_idx_t out_sel [PORT_NUM],
	output port_vec_t out_send
);

	// per output state
	port_vec_t held;
	port_idx_t hold_in [PORT_NUM];
	port_idx_t rr_ptr [PORT_NUM];

	port_idx_t pick [PORT_NUM];
	port_vec_t pick_valid;
	port_vec_t win_valid;

	// first requester after the round robin pointer wins
	always_comb begin
		int idx;
		for (int o = 0; o < PORT_NUM; o++) begin
			pick[o] = rr_ptr[o];
			pick_valid[o] = 1'b0;
			// walk backwards so the nearest candidate is assigned last
			for (int k = PORT_NUM; k >= 1; k--) begin
				idx = (int'(rr_ptr[o]) + k) % PORT_NUM;
				if (req_valid[idx] && req_port[idx] == port_idx_t'(o)) begin
					pick[o] = port_idx_t'(idx);
					pick_valid[o] = 1'b1;
				end
			end
		end
	end

	// held outputs stay with their input until the tail leaves
	always_comb begin
		pop = '0;
		for (int o = 0; o < PORT_NUM; o++) begin
			out_sel[o] = held[o] ? hold_in[o] : pick[o];
			win_valid[o] = held[o] ? req_valid[hold_in[o]] : pick_valid[o];
			// send only with downstream credit
			out_send[o] = win_valid[o] && credit_avail[o];
			if (out_send[o])
				pop[out_sel[o]] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= '0;
			for (int o = 0; o < PORT_NUM; o++)
				rr_ptr[o] <= port_idx_t'(PORT_NUM - 1);
		end else begin
			for (int o = 0; o < PORT_NUM; o++) begin
				if (out_send[o]) begin
					if (req_tail[out_sel[o]]) begin
						held[o] <= 1'b0;
						// last winner gets lowest priority next time
						rr_ptr[o] <= out_sel[o];
					end else begin
						held[o] <= 1'b1;
					end
				end
			end
		end
	end

	// capture the owner when a packet head goes out
	always_ff @(posedge clk) begin
		for (int o = 0; o < PORT_NUM; o++) begin
			if (out_send[o] && !held[o])
				hold_in[o] <= out_sel[o];
		end
	end

	// the owner of a held output keeps routing its packet there
	genvar g;
	generate
		for (g = 0; g < PORT_NUM; g++) begin : gen_hold_chk
			a_hold_route: assert property (@(posedge clk) disable iff (rst)
				held[g] && req_valid[hold_in[g]] |-> req_port[hold_in[g]] == port_idx_t'(g));
		end
	endgenerate

	// every sending output pops its own input
	a_pop_per_send: assert property (@(posedge clk) disable iff (rst)
		$countones(pop) == $countones(out_send));

endmodule

`default_nettype wire

//--- hdl/input_port.sv
`timescale 1ns/1ps
`default_nettype none

module input_port import noc_pkg::*; (
	input logic clk,
	input logic rst,
	input port_idx_t port_id,
	input link_t link_in,
	input logic pop,
	output flit_t head_flit,
	output logic req_valid,
	output logic req_tail,
	output port_idx_t req_port,
	output logic credit_out
);

	flit_t mem [BUF_DEPTH];
	logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;
	logic [$clog2(BUF_DEPTH)-1:0] rd_ptr;
	logic [CREDIT_W-1:0] count;
	logic wr_last;
	logic in_pkt;
	port_idx_t route_q;
	port_idx_t route_xy;

	// dimension order routing resolves x before y
	function automatic port_idx_t xy_route(input flit_t f);
		port_idx_t p;
		if (f.dest_x > ADDR_X_W'(ROUTER_X))
			p = PORT_EAST;
		else if (f.dest_x < ADDR_X_W'(ROUTER_X))
			p = PORT_WEST;
		else if (f.dest_y > ADDR_Y_W'(ROUTER_Y))
			p = PORT_NORTH;
		else if (f.dest_y < ADDR_Y_W'(ROUTER_Y))
			p = PORT_SOUTH;
		else
			p = PORT_LOCAL;
		return p;
	endfunction

	// flit storage
	always_ff @(posedge clk) begin
		if (link_in.wr_en)
			mem[wr_ptr] <= link_in.flit;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			wr_last <= 1'b0;
			credit_out <= 1'b0;
		end else begin
			if (link_in.wr_en)
				wr_ptr <= (wr_ptr == BUF_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == BUF_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			count <= count + CREDIT_W'(link_in.wr_en) - CREDIT_W'(pop);
			wr_last <= link_in.wr_en;
			// one slot freed per pop
			credit_out <= pop;
		end
	end

	assign head_flit = mem[rd_ptr];
	assign route_xy = xy_route(head_flit);

	// a flit written at the last edge is still being read out of the buffer
	assign req_valid = count > CREDIT_W'(wr_last);
	assign req_tail = (head_flit.kind == FLIT_TAIL) || (head_flit.kind == FLIT_SINGLE);

	// body flits follow the route taken by their head
	assign req_port = in_pkt ? route_q : route_xy;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_pkt <= 1'b0;
		end else if (pop) begin
			if (head_flit.kind == FLIT_HEAD)
				in_pkt <= 1'b1;
			else if (head_flit.kind == FLIT_TAIL)
				in_pkt <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pop && !in_pkt)
			route_q <= route_xy;
	end

	// upstream must respect the credits it was given
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		link_in.wr_en |-> count < CREDIT_W'(BUF_DEPTH));

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop |-> req_valid);

	a_pkt_start: assert property (@(posedge clk) disable iff (rst)
		req_valid && !in_pkt |-> head_flit.kind inside {FLIT_HEAD, FLIT_SINGLE});

	// xy from a neighbour never turns back the way it came
	a_no_u_turn: assert property (@(posedge clk) disable iff (rst)
		req_valid |-> (req_port != port_id) || (port_id == PORT_LOCAL));

endmodule

`default_nettype wire

//--- hdl/noc_pkg.sv
`default_nettype none

package noc_pkg;

	// router ports and mesh geometry
	localparam int PORT_NUM = 5;
	localparam int PORT_W = $clog2(PORT_NUM);
	localparam int MESH_X = 4;
	localparam int MESH_Y = 3;
	localparam int ADDR_X_W = $clog2(MESH_X);
	localparam int ADDR_Y_W = $clog2(MESH_Y);

	// position of this router in the mesh
	localparam int ROUTER_X = 2;
	localparam int ROUTER_Y = 1;

	// buffering and credits
	localparam int BUF_DEPTH = 4;
	localparam int CREDIT_W = $clog2(BUF_DEPTH + 1);

	localparam int DATA_W = 10;

	typedef logic [PORT_NUM-1:0] port_vec_t;
	typedef logic [PORT_W-1:0] port_idx_t;

	// north is larger y, east is larger x
	localparam port_idx_t PORT_LOCAL = 3'd0;
	localparam port_idx_t PORT_EAST = 3'd1;
	localparam port_idx_t PORT_NORTH = 3'd2;
	localparam port_idx_t PORT_WEST = 3'd3;
	localparam port_idx_t PORT_SOUTH = 3'd4;

	typedef enum logic [1:0] {
		FLIT_HEAD,
		FLIT_BODY,
		FLIT_TAIL,
		FLIT_SINGLE
	} flit_kind_e;

	// dest fields only meaningful in head and single flits
	typedef struct packed {
		flit_kind_e kind;
		logic [ADDR_X_W-1:0] dest_x;
		logic [ADDR_Y_W-1:0] dest_y;
		logic [DATA_W-1:0] data;
	} flit_t;

	typedef struct packed {
		logic wr_en;
		flit_t flit;
	} link_t;

endpackage

`default_nettype wire
